/* flist.f */
+incdir+rtl
rtl/patch_pkg.sv
rtl/fx_mult.sv
rtl/patch_row_reducer.sv
rtl/patch_dispatcher.sv
rtl/result_collector.sv
rtl/patch_reduce_top.sv
tests/tb_clock.sv
tests/patch_checker.sv
tests/patch_reduce_tb.sv

/* tests/patch_reduce_tb.sv */
`timescale 1ns/1ps
`include "patch_params.svh"

module patch_reduce_tb import patch_pkg::*; ();

  localparam int ROWS        = 16;
  localparam int COLS        = 32;
  localparam int NUM_FRAMES  = 10;
  localparam int FRAME_BEATS = ROWS * COLS / 2;
  localparam int PERIOD_NS   = 100;
  localparam int DRAIN_CYCLES = 64;
  // at most one idle cycle per beat, plus config and drain time
  localparam int WATCHDOG_NS = NUM_FRAMES * FRAME_BEATS * 2 * PERIOD_NS + 2000 * PERIOD_NS;

  logic          CLK;
  logic          RESET;
  logic          stream_valid;
  beat_t         stream;
  logic          cfg_valid;
  patch_cfg_t    cfg;
  logic          cfg_ready;
  logic          res_valid;
  patch_result_t res;
  logic          flush;

  int mismatches;
  int missing;
  int unexpected;
  int duplicates;
  int other_errors;
  int total;
  int next_num;

  logic [31:0]      lfsr;
  logic [`FP_W-1:0] frame [ROWS][COLS];
  patch_cfg_t       pc;

  tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(8)) u_clock (
    .CLK   (CLK),
    .RESET (RESET)
  );

  patch_reduce_top DUT (
    .CLK          (CLK),
    .RESET        (RESET),
    .stream_valid (stream_valid),
    .stream       (stream),
    .cfg_valid    (cfg_valid),
    .cfg          (cfg),
    .cfg_ready    (cfg_ready),
    .res_valid    (res_valid),
    .res          (res)
  );

  patch_checker u_checker (
    .CLK        (CLK),
    .RESET      (RESET),
    .res_valid  (res_valid),
    .res        (res),
    .flush      (flush),
    .mismatches (mismatches),
    .missing    (missing),
    .unexpected (unexpected),
    .duplicates (duplicates)
  );

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // expected sum straight from the arithmetic rule
  function automatic logic [`ACC_W-1:0] ref_sum(input patch_cfg_t c);
    logic signed [`ACC_W-1:0] acc;
    logic signed [`ACC_W-1:0] s;
    logic signed [`ACC_W-1:0] w;
    logic signed [`ACC_W-1:0] p;
    acc = c.init_sum;
    for (int k = 0; k < `PATCH_SIZE; k++) begin
      s   = $signed(frame[c.row][c.col + k]);
      w   = $signed(c.weights[k]);
      p   = (s * w) >>> `FRAC_BITS;
      acc = acc + p;
    end
    return acc;
  endfunction

  function automatic patch_cfg_t new_patch(input int row, input int col);
    patch_cfg_t c;
    c.num      = `NUM_W'(next_num);
    next_num++;
    c.row      = `ROW_W'(row);
    c.col      = `COL_W'(col);
    c.init_sum = rand_bits(32);
    for (int k = 0; k < `PATCH_SIZE; k++) begin
      c.weights[k] = rand_bits(16);
    end
    return c;
  endfunction

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic fill_frame();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        frame[r][c] = rand_bits(16);
      end
    end
  endtask

  task automatic send_cfg(input patch_cfg_t c);
    patch_result_t e;
    while (cfg_ready !== 1'b1) next_cycle();
    cfg_valid = 1'b1;
    cfg       = c;
    e.num     = c.num;
    e.sum     = ref_sum(c);
    u_checker.exp_q.push_back(e);
    next_cycle();
    cfg_valid = 1'b0;
  endtask

  task automatic send_frame(input bit gaps);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c += 2) begin
        if (gaps && rand_bits(2) == 32'd3) begin
          stream_valid = 1'b0;
          next_cycle();
        end
        stream_valid = 1'b1;
        stream.row   = `ROW_W'(r);
        stream.l_col = `COL_W'(c);
        stream.fds0  = frame[r][c];
        stream.fds1  = frame[r][c + 1];
        next_cycle();
      end
    end
    stream_valid = 1'b0;
  endtask

  initial begin
    stream_valid = 1'b0;
    stream       = '0;
    cfg_valid    = 1'b0;
    cfg          = '0;
    flush        = 1'b0;
    lfsr         = 32'hc261_70c7;
    next_num     = 0;
    other_errors = 0;

    @(negedge RESET);
    if (cfg_ready !== 1'b1 || res_valid !== 1'b0) begin
      $display("[FAIL] %0t: after reset cfg_ready=%b res_valid=%b", $time, cfg_ready, res_valid);
      other_errors++;
    end

    for (int f = 0; f < NUM_FRAMES; f++) begin
      fill_frame();
      if (f == 0) begin
        // unit weights, product equals the score
        pc = new_patch(2, 4);
        for (int k = 0; k < `PATCH_SIZE; k++) begin
          pc.weights[k] = 16'h0100;
        end
        send_cfg(pc);
      end else if (f == 1) begin
        send_cfg(new_patch(0, 1));
        send_cfg(new_patch(15, 23));
        send_cfg(new_patch(3, 7));
        send_cfg(new_patch(8, 13));
      end else if (f == 2) begin
        // two lanes end together
        send_cfg(new_patch(5, 10));
        send_cfg(new_patch(5, 10));
        send_cfg(new_patch(5, 11));
        send_cfg(new_patch(5, 12));
      end else if (f == 3) begin
        for (int k = 0; k < `PATCH_SIZE; k++) begin
          frame[9][6 + k]  = 16'h7f00;
          frame[12][20 + k] = 16'h7f00;
        end
        // overflow past the top and past the bottom
        pc = new_patch(9, 6);
        pc.init_sum = 32'h7fff_0000;
        for (int k = 0; k < `PATCH_SIZE; k++) begin
          pc.weights[k] = 16'h7fff;
        end
        send_cfg(pc);
        pc = new_patch(12, 20);
        pc.init_sum = 32'h8000_0100;
        for (int k = 0; k < `PATCH_SIZE; k++) begin
          pc.weights[k] = 16'h8000;
        end
        send_cfg(pc);
        send_cfg(new_patch(rand_bits(4), rand_bits(5) % 25));
        send_cfg(new_patch(rand_bits(4), rand_bits(5) % 25));
      end else begin
        for (int n = rand_bits(2); n >= 0; n--) begin
          send_cfg(new_patch(rand_bits(4), rand_bits(5) % 25));
        end
      end
      // lanes reach match wait before the first beat
      next_cycle();
      next_cycle();
      send_frame(f >= 4);
      // results trail the last beat by a few cycles
      for (int t = 0; t < DRAIN_CYCLES && u_checker.exp_q.size() != 0; t++) begin
        next_cycle();
      end
    end

    repeat (20) next_cycle();
    flush = 1'b1;
    #1;
    total = mismatches + missing + unexpected + duplicates + other_errors;
    $display("errors: %0d mismatched, %0d missing, %0d unexpected, %0d duplicate, %0d other",
             mismatches, missing, unexpected, duplicates, other_errors);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, results still outstanding: %0d",
             WATCHDOG_NS, u_checker.exp_q.size());
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* tests/patch_checker.sv */
`timescale 1ns/1ps
`include "patch_params.svh"

module patch_checker import patch_pkg::*; (
  input  logic          CLK,
  input  logic          RESET,
  input  logic          res_valid,
  input  patch_result_t res,
  input  logic          flush,
  output int            mismatches,
  output int            missing,
  output int            unexpected,
  output int            duplicates
);

  // expected results, pushed by the testbench top
  patch_result_t exp_q [$];

  // patch numbers already reported
  bit seen [2**`NUM_W];

  int n_mismatch   = 0;
  int n_missing    = 0;
  int n_unexpected = 0;
  int n_duplicate  = 0;

  assign mismatches = n_mismatch;
  assign missing    = n_missing;
  assign unexpected = n_unexpected;
  assign duplicates = n_duplicate;

  // results are registered, so mid-cycle is stable
  always @(negedge CLK) begin : compare
    int idx;
    idx = -1;
    if (!RESET && res_valid === 1'b1) begin
      for (int i = 0; i < exp_q.size(); i++) begin
        if (exp_q[i].num == res.num) begin
          idx = i;
        end
      end
      if (idx >= 0) begin
        if (exp_q[idx].sum !== res.sum) begin
          $display("[FAIL] %0t: patch %0d sum %h, expected %h",
                   $time, res.num, res.sum, exp_q[idx].sum);
          n_mismatch++;
        end
        seen[res.num] = 1'b1;
        exp_q.delete(idx);
      end else if (seen[res.num]) begin
        $display("duplicate result for patch %0d at %0t", res.num, $time);
        n_duplicate++;
      end else begin
        $display("unexpected result for patch %0d at %0t", res.num, $time);
        n_unexpected++;
      end
    end else if (!RESET && res_valid !== 1'b0) begin
      $display("res_valid is unknown at %0t", $time);
      n_unexpected++;
    end
  end

  // anything still queued at the end never came out
  always @(posedge flush) begin : report_missing
    foreach (exp_q[i]) begin
      $display("missing result for patch %0d", exp_q[i].num);
      n_missing++;
    end
  end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic CLK,
  output logic RESET
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // release lines up with the stimulus drive point
  initial begin
    RESET = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 RESET = 1'b0;
  end

endmodule

/* rtl/patch_reduce_top.sv */
`timescale 1ns/1ps
`include "patch_params.svh"

module patch_reduce_top import patch_pkg::*; (
  input  logic          CLK,
  input  logic          RESET,
  input  logic          stream_valid,
  input  beat_t         stream,
  input  logic          cfg_valid,
  input  patch_cfg_t    cfg,
  output logic          cfg_ready,
  output logic          res_valid,
  output patch_result_t res
);

  logic [`N_LANES-1:0] init;
  logic [`N_LANES-1:0] available;
  logic [`N_LANES-1:0] done;
  patch_cfg_t          cfg_q;
  patch_result_t       lane_res [`N_LANES];

  patch_dispatcher u_dispatcher (
    .CLK       (CLK),
    .RESET     (RESET),
    .cfg_valid (cfg_valid),
    .cfg       (cfg),
    .available (available),
    .cfg_ready (cfg_ready),
    .init      (init),
    .cfg_q     (cfg_q)
  );

  // reducer lanes share the stream and the registered config
  for (genvar g = 0; g < `N_LANES; g++) begin : g_lane
    patch_row_reducer u_lane (
      .CLK          (CLK),
      .RESET        (RESET),
      .init         (init[g]),
      .cfg          (cfg_q),
      .stream_valid (stream_valid),
      .stream       (stream),
      .available    (available[g]),
      .done         (done[g]),
      .result       (lane_res[g])
    );
  end

  result_collector u_collector (
    .CLK       (CLK),
    .RESET     (RESET),
    .done      (done),
    .lane_res  (lane_res),
    .res_valid (res_valid),
    .res       (res)
  );

endmodule

/* rtl/result_collector.sv */
`timescale 1ns/1ps
`include "patch_params.svh"

module result_collector import patch_pkg::*; (
  input  logic                CLK,
  input  logic                RESET,
  input  logic [`N_LANES-1:0] done,
  input  patch_result_t       lane_res [`N_LANES],
  output logic                res_valid,
  output patch_result_t       res
);

  logic [`N_LANES-1:0] pend;
  logic [`N_LANES-1:0] req;
  logic [`N_LANES-1:0] grant;
  patch_result_t       hold [`N_LANES];
  patch_result_t       pick;

  // a fresh done competes with lanes already waiting
  assign req   = pend | done;
  assign grant = req & (~req + 1'b1);

  always_comb begin
    pick = '0;
    for (int i = 0; i < `N_LANES; i++) begin
      if (grant[i]) begin
        pick = pend[i] ? hold[i] : lane_res[i];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      pend      <= '0;
      res_valid <= 1'b0;
    end else begin
      pend      <= req & ~grant;
      res_valid <= |req;
    end
  end

  always_ff @(posedge CLK) begin
    res <= pick;
    for (int i = 0; i < `N_LANES; i++) begin
      if (done[i]) begin
        hold[i] <= lane_res[i];
      end
    end
  end

  // a lane cannot finish again before its last result went out
  a_no_overrun: assert property (@(posedge CLK) disable iff (RESET)
    (done & pend) == '0);

endmodule

/* rtl/patch_dispatcher.sv */
`timescale 1ns/1ps
`include "patch_params.svh"

module patch_dispatcher import patch_pkg::*; (
  input  logic                CLK,
  input  logic                RESET,
  input  logic                cfg_valid,
  input  patch_cfg_t          cfg,
  input  logic [`N_LANES-1:0] available,
  output logic                cfg_ready,
  output logic [`N_LANES-1:0] init,
  output patch_cfg_t          cfg_q
);

  logic [`N_LANES-1:0] free;
  logic [`N_LANES-1:0] sel;

  // lane pulsed this cycle still shows available, so hide it
  assign free      = available & ~init;
  assign cfg_ready = |free;

  // lowest set bit
  assign sel = free & (~free + 1'b1);

  always_ff @(posedge CLK) begin
    if (RESET) begin
      init <= '0;
    end else if (cfg_valid) begin
      init <= sel;
    end else begin
      init <= '0;
    end
  end

  always_ff @(posedge CLK) begin
    if (cfg_valid) begin
      cfg_q <= cfg;
    end
  end

  a_cfg_ready: assert property (@(posedge CLK) disable iff (RESET)
    cfg_valid |-> cfg_ready);

  // back-to-back configs must land on distinct lanes
  a_one_init: assert property (@(posedge CLK) disable iff (RESET)
    $onehot0(init));

endmodule

/* rtl/patch_row_reducer.sv */
`timescale 1ns/1ps
`include "patch_params.svh"

module patch_row_reducer import patch_pkg::*; (
  input  logic          CLK,
  input  logic          RESET,
  input  logic          init,
  input  patch_cfg_t    cfg,
  input  logic          stream_valid,
  input  beat_t         stream,
  output logic          available,
  output logic          done,
  output patch_result_t result
);

  localparam int IDX_W = $clog2(`PATCH_SIZE + 1);
  localparam int WI_W  = $clog2(`PATCH_SIZE);

  typedef enum logic [2:0] {
    s_config_wait,
    s_match_wait,
    s_matched,
    s_sum_wait,
    s_sum_rdy
  } state_t;

  state_t state;

  logic [`NUM_W-1:0]                 num_q;
  logic [`ROW_W-1:0]                 row_q;
  logic [`COL_W-1:0]                 col_q;
  logic [`PATCH_SIZE-1:0][`FP_W-1:0] wt_q;
  logic [`ACC_W-1:0]                 sum_q;

  logic [IDX_W-1:0] idx;
  logic [IDX_W-1:0] idx_p1;
  logic [IDX_W-1:0] idx_nxt;
  logic [IDX_W-1:0] issue_cnt;
  logic [IDX_W-1:0] acc_cnt;

  logic             hit;
  logic             issue0;
  logic             issue1;
  logic             beat;
  logic [`FP_W-1:0] w0;
  logic [`FP_W-1:0] w1;

  logic                     mv0;
  logic                     mv1;
  logic signed [`ACC_W-1:0] p0;
  logic signed [`ACC_W-1:0] p1;
  logic                     pair_vld;
  logic [`ACC_W-1:0]        pair_sum;

  // start beat carries the even column at or below the start column
  assign hit    = stream_valid && (stream.row == row_q)
                  && (stream.l_col == {col_q[`COL_W-1:1], 1'b0});
  assign idx_p1 = idx + 1'b1;

  always_comb begin
    issue0  = 1'b0;
    issue1  = 1'b0;
    w0      = wt_q[0];
    w1      = wt_q[1];
    idx_nxt = idx;
    if (state == s_match_wait && hit) begin
      // odd start drops the left pixel
      issue0  = !col_q[0];
      issue1  = 1'b1;
      w1      = col_q[0] ? wt_q[0] : wt_q[1];
      idx_nxt = col_q[0] ? IDX_W'(1) : IDX_W'(2);
    end else if (state == s_matched && stream_valid) begin
      issue0  = 1'b1;
      issue1  = idx_p1 < IDX_W'(`PATCH_SIZE);
      w0      = wt_q[idx[WI_W-1:0]];
      w1      = issue1 ? wt_q[idx_p1[WI_W-1:0]] : '0;
      idx_nxt = idx + (issue1 ? IDX_W'(2) : IDX_W'(1));
    end
  end

  assign beat = issue0 | issue1;

  fx_mult u_mult0 (
    .CLK       (CLK),
    .RESET     (RESET),
    .in_valid  (issue0),
    .a         (stream.fds0),
    .b         (w0),
    .out_valid (mv0),
    .product   (p0)
  );

  fx_mult u_mult1 (
    .CLK       (CLK),
    .RESET     (RESET),
    .in_valid  (issue1),
    .a         (stream.fds1),
    .b         (w1),
    .out_valid (mv1),
    .product   (p1)
  );

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state     <= s_config_wait;
      idx       <= '0;
      issue_cnt <= '0;
    end else begin
      case (state)
        s_config_wait: begin
          if (init) begin
            state     <= s_match_wait;
            idx       <= '0;
            issue_cnt <= '0;
          end
        end
        s_match_wait: begin
          if (beat) begin
            state     <= s_matched;
            idx       <= idx_nxt;
            issue_cnt <= issue_cnt + 1'b1;
          end
        end
        s_matched: begin
          if (beat) begin
            idx       <= idx_nxt;
            issue_cnt <= issue_cnt + 1'b1;
            if (idx_nxt == IDX_W'(`PATCH_SIZE)) begin
              state <= s_sum_wait;
            end
          end
        end
        // every issued beat has reached the accumulator
        s_sum_wait: begin
          if (issue_cnt == acc_cnt) begin
            state <= s_sum_rdy;
          end
        end
        s_sum_rdy: state <= s_config_wait;
        default:   state <= s_config_wait;
      endcase
    end
  end

  // pair add stage
  always_ff @(posedge CLK) begin
    if (RESET) begin
      pair_vld <= 1'b0;
    end else begin
      pair_vld <= mv0 | mv1;
    end
    pair_sum <= (mv0 ? p0 : '0) + (mv1 ? p1 : '0);
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      acc_cnt <= '0;
    end else if (init) begin
      acc_cnt <= '0;
    end else if (pair_vld) begin
      acc_cnt <= acc_cnt + 1'b1;
    end
  end

  // patch payload and wrapping accumulator
  always_ff @(posedge CLK) begin
    if (init) begin
      num_q <= cfg.num;
      row_q <= cfg.row;
      col_q <= cfg.col;
      wt_q  <= cfg.weights;
      sum_q <= cfg.init_sum;
    end else if (pair_vld) begin
      sum_q <= sum_q + pair_sum;
    end
  end

  assign available  = (state == s_config_wait);
  assign done       = (state == s_sum_rdy);
  assign result.num = num_q;
  assign result.sum = sum_q;

  // dispatcher may only claim an idle lane
  a_init_idle: assert property (@(posedge CLK) disable iff (RESET)
    init |-> state == s_config_wait);

endmodule

/* rtl/fx_mult.sv */
`timescale 1ns/1ps
`include "patch_params.svh"

module fx_mult (
  input  logic                     CLK,
  input  logic                     RESET,
  input  logic                     in_valid,
  input  logic signed [`FP_W-1:0]  a,
  input  logic signed [`FP_W-1:0]  b,
  output logic                     out_valid,
  output logic signed [`ACC_W-1:0] product
);

  localparam int LAT = `MULT_LAT;

  logic signed [`FP_W-1:0]  a_q;
  logic signed [`FP_W-1:0]  b_q;
  logic signed [`ACC_W-1:0] prod_q;
  logic [LAT-1:0]           vld_sr;

  // operands, full product, then back to Q8.8 scale
  always_ff @(posedge CLK) begin
    a_q     <= a;
    b_q     <= b;
    prod_q  <= a_q * b_q;
    product <= prod_q >>> `FRAC_BITS;
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[LAT-2:0], in_valid};
    end
  end

  assign out_valid = vld_sr[LAT-1];

  // valid must line up with the three data stages
  a_lat: assert property (@(posedge CLK) disable iff (RESET)
    in_valid |-> ##LAT out_valid);

endmodule

/* rtl/patch_pkg.sv */
`include "patch_params.svh"

package patch_pkg;

  // one stream beat, two pixels, left column always even
  typedef struct packed {
    logic [`ROW_W-1:0] row;
    logic [`COL_W-1:0] l_col;
    logic [`FP_W-1:0]  fds0;
    logic [`FP_W-1:0]  fds1;
  } beat_t;

  // patch configuration, weight k applies to pixel col + k
  typedef struct packed {
    logic [`NUM_W-1:0]                  num;
    logic [`ROW_W-1:0]                  row;
    logic [`COL_W-1:0]                  col;
    logic [`ACC_W-1:0]                  init_sum;
    logic [`PATCH_SIZE-1:0][`FP_W-1:0]  weights;
  } patch_cfg_t;

  // finished patch
  typedef struct packed {
    logic [`NUM_W-1:0] num;
    logic [`ACC_W-1:0] sum;
  } patch_result_t;

endpackage

/* rtl/patch_params.svh */
`ifndef PATCH_PARAMS_SVH
`define PATCH_PARAMS_SVH

// patch geometry and lane count
`define PATCH_SIZE 8
`define N_LANES    4

// Q8.8 scores and weights, wrapping accumulator
`define FP_W       16
`define FRAC_BITS  8
`define ACC_W      32

// stream tag and patch number widths
`define ROW_W      6
`define COL_W      6
`define NUM_W      8

// fx_mult pipeline depth
`define MULT_LAT   3

`endif
